/* logic/dtePkg.sv */
`default_nettype none

package dtePkg;

  localparam int DefTickWidth  = 32;
  localparam int DefReqDepth   = 4;
  localparam int DefReplyDepth = 4;

  typedef logic [0:35] tWord;   // bit 0 is the msb as on the backplane

  typedef enum logic [2:0] {
    dteMisc            = 3'd0,
    dteDiagWrite       = 3'd1,
    dteDiagFunc        = 3'd2,
    dteDiagRead        = 3'd3,
    dteReleaseEBUSData = 3'd4
  } tReqType;

  // codes as they appear on the bus select lines
  typedef enum logic [6:0] {
    diagNone       = 7'o000,
    funcStart      = 7'o001,
    funcStop       = 7'o002,
    funcSingleStep = 7'o004,
    funcClrReset   = 7'o006,
    funcSetReset   = 7'o007,
    ldDiagAr       = 7'o042,
    rdDiagAr       = 7'o043,
    clrCROBAR      = 7'o070
  } tDiagFunction;

  typedef struct packed {
    tReqType                 reqType;
    tDiagFunction            diagReq;
    tWord                    reqData;
    logic [DefTickWidth-1:0] reqTime;   // tick at which the request may run
  } tRequest;

  typedef struct packed {
    tReqType                 replyType;
    tDiagFunction            replyFunc;
    tWord                    replyData;   // bus word sampled at the action
    logic [DefTickWidth-1:0] replyTime;
  } tReply;

endpackage

`default_nettype wire

/* logic/dteIfc.sv */
`default_nettype none

// decode offers the due head request to execute
interface dteReqIfc #(
  parameter int TickWidth = dtePkg::DefTickWidth
);
  import dtePkg::*;

  logic                 valid;
  logic                 ready;
  tRequest              item;
  logic [TickWidth-1:0] tick;   // tick at the offer

  modport decode (
    output valid,
    output item,
    output tick,
    input  ready
  );

  modport execute (
    input  valid,
    input  item,
    input  tick,
    output ready
  );
endinterface

// execute hands the finished action to result
interface dteExecIfc #(
  parameter int TickWidth = dtePkg::DefTickWidth
);
  import dtePkg::*;

  logic                 valid;
  logic                 ready;
  tReqType              reqType;
  tDiagFunction         func;
  tWord                 data;
  logic [TickWidth-1:0] tick;

  modport execute (output valid, output reqType, output func, output data, output tick,
                   input ready);

  modport result (input valid, input reqType, input func, input data, input tick,
                  output ready);
endinterface

`default_nettype wire

/* logic/creditFifo.sv */
`default_nettype none

module creditFifo #(
  parameter type ItemType = logic,
  parameter int  Depth    = 4
) (
  input  wire logic    clk,
  input  wire logic    reqPending,
  input  wire logic    push,
  input  wire ItemType pushItem,
  input  wire logic    pop,
  output ItemType      popItem,
  output logic         empty,
  output logic         full,
  output logic         creditReturn
);

  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntWidth = $clog2(Depth + 1);

  ItemType             mem [Depth];
  logic [PtrWidth-1:0] rdPtr;
  logic [PtrWidth-1:0] wrPtr;
  logic [CntWidth-1:0] count;

  // wraps at Depth, so any depth works
  function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] p);
    return (p == PtrWidth'(Depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty   = (count == '0);
  assign full    = (count == CntWidth'(Depth));
  assign popItem = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (push) mem[wrPtr] <= pushItem;
  end

  always_ff @(posedge clk or negedge reqPending) begin
    if (!reqPending) begin
      rdPtr        <= '0;
      wrPtr        <= '0;
      count        <= '0;
      creditReturn <= 1'b0;
    end else begin
      if (push) wrPtr <= nextPtr(wrPtr);
      if (pop) rdPtr <= nextPtr(rdPtr);
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
      creditReturn <= pop;   // one slot freed, one credit back
    end
  end

endmodule

`default_nettype wire

/* logic/dteDecode.sv */
`default_nettype none

module dteDecode #(
  parameter int TickWidth = dtePkg::DefTickWidth,
  parameter int ReqDepth  = dtePkg::DefReqDepth
) (
  input  wire logic           clk,
  input  wire logic           reqPending,
  input  wire logic           reqValid,
  input  wire dtePkg::tRequest reqIn,
  output logic                reqCreditReturn,
  dteReqIfc.decode            issue
);
  import dtePkg::*;

  logic [TickWidth-1:0] ticks;
  logic [TickWidth-1:0] headTime;
  tRequest              head;
  logic                 empty;
  logic                 full;
  logic                 push;
  logic                 pop;
  logic                 due;

  // free-running tick counter
  always_ff @(posedge clk or negedge reqPending) begin
    if (!reqPending) begin
      ticks <= '0;
    end else begin
      ticks <= ticks + 1'b1;
    end
  end

  // a host over its credits would overrun the queue, so its request is dropped
  assign push = reqValid && !full;

  creditFifo #(
    .ItemType (tRequest),
    .Depth    (ReqDepth)
  ) reqQueue (
    .clk          (clk),
    .reqPending   (reqPending),
    .push         (push),
    .pushItem     (reqIn),
    .pop          (pop),
    .popItem      (head),
    .empty        (empty),
    .full         (full),
    .creditReturn (reqCreditReturn)
  );

  assign headTime = head.reqTime[TickWidth-1:0];

  // only the head is scheduled, later requests wait behind it
  assign due = !empty && (ticks >= headTime);

  assign issue.valid = due;
  assign issue.item  = head;
  assign issue.tick  = ticks;   // follows the counter while execute stalls

  assign pop = due && issue.ready;

endmodule

`default_nettype wire

/* logic/dteExecute.sv */
`default_nettype none

module dteExecute (
  input  wire logic        clk,
  input  wire logic        reqPending,
  dteReqIfc.execute        issue,
  dteExecIfc.execute       done,
  input  wire dtePkg::tWord ebusData,
  output dtePkg::tDiagFunction ebusDs,
  output logic             diagStrobe,
  output logic             ebusDriving,
  output dtePkg::tWord     ebusDriveData,
  output logic             crobar
);
  import dtePkg::*;

  tRequest req;
  logic    take;
  logic    strobeReq;

  assign req = issue.item;

  // the result slot is free, or result takes it this cycle
  assign issue.ready = !done.valid || done.ready;
  assign take        = issue.valid && issue.ready;

  assign strobeReq = (req.reqType == dteDiagWrite) || (req.reqType == dteDiagFunc);

  always_ff @(posedge clk or negedge reqPending) begin
    if (!reqPending) begin
      done.valid    <= 1'b0;
      diagStrobe    <= 1'b0;
      ebusDs        <= diagNone;
      ebusDriving   <= 1'b0;
      ebusDriveData <= '0;
      crobar        <= 1'b1;   // machine held in crowbar until cleared
    end else begin
      done.valid <= take || (done.valid && !done.ready);
      diagStrobe <= take && strobeReq;   // single cycle per request
      if (take) begin
        case (req.reqType)
          dteDiagWrite: begin
            ebusDs        <= req.diagReq;
            ebusDriving   <= 1'b1;
            ebusDriveData <= req.reqData;
          end
          dteDiagFunc:  ebusDs <= req.diagReq;
          dteReleaseEBUSData: begin
            ebusDriving   <= 1'b0;
            ebusDriveData <= '0;
          end
          dteMisc: begin
            if (req.diagReq == clrCROBAR) crobar <= 1'b0;
          end
          default: ;   // a read drives nothing
        endcase
      end
    end
  end

  // bus word is taken on the transfer cycle, before this action drives anything
  always_ff @(posedge clk) begin
    if (take) begin
      done.reqType <= req.reqType;
      done.func    <= req.diagReq;
      done.data    <= ebusData;
      done.tick    <= issue.tick;
    end
  end

endmodule

`default_nettype wire

/* logic/dteResult.sv */
`default_nettype none

module dteResult #(
  parameter int TickWidth  = dtePkg::DefTickWidth,
  parameter int ReplyDepth = dtePkg::DefReplyDepth
) (
  input  wire logic             clk,
  input  wire logic             reqPending,
  dteExecIfc.result             done,
  input  wire logic             replyCredit,
  output logic                  replyValid,
  output dtePkg::tReqType       replyType,
  output dtePkg::tDiagFunction  replyFunc,
  output dtePkg::tWord          replyData,
  output logic [TickWidth-1:0]  replyTime
);
  import dtePkg::*;

  localparam int CreditWidth = $clog2(ReplyDepth + 1) + 4;   // host may grant ahead

  tReply                  newReply;
  tReply                  headReply;
  logic                   push;
  logic                   pop;
  logic                   empty;
  logic                   full;
  logic [CreditWidth-1:0] credits;

  assign done.ready = !full;
  assign push       = done.valid && !full;

  assign newReply = '{
    replyType: done.reqType,
    replyFunc: done.func,
    replyData: done.data,
    replyTime: DefTickWidth'(done.tick)
  };

  creditFifo #(
    .ItemType (tReply),
    .Depth    (ReplyDepth)
  ) replyQueue (
    .clk          (clk),
    .reqPending   (reqPending),
    .push         (push),
    .pushItem     (newReply),
    .pop          (pop),
    .popItem      (headReply),
    .empty        (empty),
    .full         (full),
    .creditReturn (replyValid)   // pulse lines up with the registered fields
  );

  assign pop = !empty && (credits != '0);

  always_ff @(posedge clk or negedge reqPending) begin
    if (!reqPending) begin
      credits <= '0;
    end else begin
      case ({replyCredit, pop})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: ;   // granted and spent together
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      replyType <= headReply.replyType;
      replyFunc <= headReply.replyFunc;
      replyData <= headReply.replyData;
      replyTime <= headReply.replyTime[TickWidth-1:0];
    end
  end

endmodule

`default_nettype wire

/* logic/dteTop.sv */
`default_nettype none

module dteTop #(
  parameter int TickWidth  = dtePkg::DefTickWidth,   // 32 at most
  parameter int ReqDepth   = dtePkg::DefReqDepth,
  parameter int ReplyDepth = dtePkg::DefReplyDepth
) (
  input  wire logic                 clk,
  input  wire logic                 reqPending,

  input  wire logic                 reqValid,
  input  wire dtePkg::tReqType      reqType,
  input  wire dtePkg::tDiagFunction diagReq,
  input  wire dtePkg::tWord         reqData,
  input  wire logic [TickWidth-1:0] reqTime,
  output logic                      reqCreditReturn,

  input  wire dtePkg::tWord         ebusData,
  output dtePkg::tDiagFunction      ebusDs,
  output logic                      diagStrobe,
  output logic                      ebusDriving,
  output dtePkg::tWord              ebusDriveData,
  output logic                      crobar,

  input  wire logic                 replyCredit,
  output logic                      replyValid,
  output dtePkg::tReqType           replyType,
  output dtePkg::tDiagFunction      replyFunc,
  output dtePkg::tWord              replyData,
  output logic [TickWidth-1:0]      replyTime
);
  import dtePkg::*;

  dteReqIfc  #(.TickWidth(TickWidth)) issueBus ();
  dteExecIfc #(.TickWidth(TickWidth)) doneBus ();

  dteDecode #(
    .TickWidth (TickWidth),
    .ReqDepth  (ReqDepth)
  ) decode0 (
    .clk             (clk),
    .reqPending      (reqPending),
    .reqValid        (reqValid),
    .reqIn           (tRequest'{reqType, diagReq, reqData, DefTickWidth'(reqTime)}),
    .reqCreditReturn (reqCreditReturn),
    .issue           (issueBus.decode)
  );

  dteExecute execute0 (
    .clk           (clk),
    .reqPending    (reqPending),
    .issue         (issueBus.execute),
    .done          (doneBus.execute),
    .ebusData      (ebusData),
    .ebusDs        (ebusDs),
    .diagStrobe    (diagStrobe),
    .ebusDriving   (ebusDriving),
    .ebusDriveData (ebusDriveData),
    .crobar        (crobar)
  );

  dteResult #(
    .TickWidth  (TickWidth),
    .ReplyDepth (ReplyDepth)
  ) result0 (
    .clk         (clk),
    .reqPending  (reqPending),
    .done        (doneBus.result),
    .replyCredit (replyCredit),
    .replyValid  (replyValid),
    .replyType   (replyType),
    .replyFunc   (replyFunc),
    .replyData   (replyData),
    .replyTime   (replyTime)
  );

endmodule

`default_nettype wire

/* testbench/dteTb.sv */
`default_nettype none

module dteTb;
  timeunit 1ns;
  timeprecision 1ps;
  import dtePkg::*;

  localparam int TickWidth  = 32;
  localparam int ReqDepth   = DefReqDepth;
  localparam int ReplyDepth = DefReplyDepth;
  localparam int NumRows    = 16;
  localparam int MaxCycles  = 40 * NumRows + 200;

  typedef struct {
    tReqType      kind;
    tDiagFunction func;
    tWord         data;
    int           offset;   // ticks after the send tick
    bit           hold;     // reply credit held back
  } tRow;

  logic                 clk = 1'b0;
  logic                 reqPending;
  logic                 reqValid;
  tReqType              reqType;
  tDiagFunction         diagReq;
  tWord                 reqData;
  logic [TickWidth-1:0] reqTime;
  logic                 reqCreditReturn;
  tWord                 ebusData;
  tDiagFunction         ebusDs;
  logic                 diagStrobe;
  logic                 ebusDriving;
  tWord                 ebusDriveData;
  logic                 crobar;
  logic                 replyCredit;
  logic                 replyValid;
  tReqType              replyType;
  tDiagFunction         replyFunc;
  tWord                 replyData;
  logic [TickWidth-1:0] replyTime;

  tRow          rows [NumRows];
  int           sentTime [NumRows];
  tWord         busHist [MaxCycles+2];   // bus word seen in each tick
  logic         strobeHist [MaxCycles+2];
  tDiagFunction dsHist [MaxCycles+2];
  logic         drvHist [MaxCycles+2];
  tWord         drvDataHist [MaxCycles+2];
  logic         crobarHist [MaxCycles+2];

  int errorCount = 0;
  int rowCount = 0;
  int strobeRows = 0;
  int sent = 0;
  int returns = 0;
  int grants = 0;
  int replies = 0;
  int strobes = 0;
  int owed = 0;
  int cycles = 0;
  int tbTick = 0;
  int lastTime = 0;
  logic expDriving = 1'b0;
  tWord expDriveData = '0;
  logic expCrobar = 1'b1;
  integer seed = 28284;
  logic [63:0] rnd;

  dteTop #(
    .TickWidth  (TickWidth),
    .ReqDepth   (ReqDepth),
    .ReplyDepth (ReplyDepth)
  ) dut0 (.*);

  always #2 clk = ~clk;

  // bus data model and a tick count that follows the DUT counter
  always @(posedge clk) begin
    rnd = {$random(seed), $random(seed)};
    ebusData <= rnd[35:0];
    if (!reqPending) tbTick <= 0;
    else tbTick <= tbTick + 1;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("timeout after %0d cycles, %0d of %0d replies received",
               cycles, replies, NumRows);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic noteMismatch(input string msg);
    $display("** Error at %0d ns: %s", $time, msg);
    errorCount++;
  endtask

  task automatic addRow(input tReqType kind, input tDiagFunction func, input tWord data,
                        input int offset, input bit hold);
    rows[rowCount] = '{kind, func, data, offset, hold};
    if (kind == dteDiagWrite || kind == dteDiagFunc) strobeRows++;
    rowCount++;
  endtask

  task automatic offerReplyCredit(input bit withhold);
    if (!withhold && owed > 0) begin
      replyCredit <= 1'b1;
      owed--;
    end else begin
      replyCredit <= 1'b0;
    end
  endtask

  // reply k belongs to row k, its action shows one tick after replyTime
  task automatic checkReply();
    int k;
    int t;
    bit strobeWanted;
    k = replies - 1;
    t = int'(replyTime);
    assert (k < NumRows && t + 1 < tbTick)
      else noteMismatch($sformatf("reply %0d with time %0d is unexpected", k, t));
    if (k < NumRows && t + 1 < tbTick) begin
      assert (replyType == rows[k].kind && replyFunc == rows[k].func)
        else noteMismatch($sformatf("reply %0d type %0d func %o, expected %0d %o", k,
                                    replyType, replyFunc, rows[k].kind, rows[k].func));
      assert (t >= sentTime[k] && t >= lastTime)
        else noteMismatch($sformatf("reply %0d time %0d, due %0d, last %0d", k, t,
                                    sentTime[k], lastTime));
      lastTime = t;
      assert (replyData == busHist[t])
        else noteMismatch($sformatf("reply %0d data %o, bus held %o", k, replyData,
                                    busHist[t]));
      case (rows[k].kind)
        dteDiagWrite: begin
          expDriving   = 1'b1;
          expDriveData = rows[k].data;
        end
        dteReleaseEBUSData: begin
          expDriving   = 1'b0;
          expDriveData = '0;
        end
        dteMisc: if (rows[k].func == clrCROBAR) expCrobar = 1'b0;
        default: ;
      endcase
      strobeWanted = (rows[k].kind == dteDiagWrite) || (rows[k].kind == dteDiagFunc);
      assert (!strobeWanted || (strobeHist[t+1] && dsHist[t+1] == rows[k].func))
        else noteMismatch($sformatf("row %0d no strobe with code %o", k, rows[k].func));
      assert (drvHist[t+1] == expDriving && drvDataHist[t+1] == expDriveData)
        else noteMismatch($sformatf("row %0d driver %0b %o, expected %0b %o", k,
                                    drvHist[t+1], drvDataHist[t+1], expDriving, expDriveData));
      assert (crobarHist[t+1] == expCrobar)
        else noteMismatch($sformatf("row %0d crobar %0b, expected %0b", k, crobarHist[t+1],
                                    expCrobar));
    end
  endtask

  always @(negedge clk) begin
    if (reqPending) begin
      busHist[tbTick]     = ebusData;
      strobeHist[tbTick]  = diagStrobe;
      dsHist[tbTick]      = ebusDs;
      drvHist[tbTick]     = ebusDriving;
      drvDataHist[tbTick] = ebusDriveData;
      crobarHist[tbTick]  = crobar;
      if (diagStrobe) strobes++;
      if (replyCredit) grants++;
      if (reqCreditReturn) returns++;
      assert (returns <= sent)
        else noteMismatch($sformatf("%0d credit returns for %0d requests", returns, sent));
      if (replyValid) begin
        replies++;
        assert (replies <= grants)
          else noteMismatch($sformatf("%0d replies on %0d reply credits", replies, grants));
        checkReply();
      end
    end
  end

  initial begin
    bit holding;
    reqPending  = 1'b0;
    reqValid    = 1'b0;
    reqType     = dteMisc;
    diagReq     = diagNone;
    reqData     = '0;
    reqTime     = '0;
    replyCredit = 1'b0;
    ebusData    = '0;
    addRow(dteDiagWrite, ldDiagAr, 36'o123456701234, 0, 1'b0);
    addRow(dteDiagRead, rdDiagAr, '0, 3, 1'b0);
    addRow(dteDiagFunc, funcStart, '0, 0, 1'b0);
    addRow(dteMisc, diagNone, '0, 0, 1'b0);            // crowbar must stay set
    addRow(dteDiagWrite, funcSetReset, 36'o777000111222, 10, 1'b0);
    addRow(dteDiagFunc, funcStop, '0, 0, 1'b0);
    // held run stays below ReplyDepth + ReqDepth + 1, else the host stalls for good
    addRow(dteDiagRead, rdDiagAr, '0, 0, 1'b1);
    addRow(dteDiagWrite, ldDiagAr, 36'o000000000007, 0, 1'b1);
    addRow(dteDiagFunc, funcSingleStep, '0, 0, 1'b1);
    addRow(dteDiagRead, rdDiagAr, '0, 0, 1'b1);
    addRow(dteDiagRead, diagNone, '0, 2, 1'b1);
    addRow(dteDiagWrite, ldDiagAr, 36'o400000000001, 0, 1'b1);
    addRow(dteReleaseEBUSData, diagNone, '0, 0, 1'b1);
    addRow(dteDiagRead, rdDiagAr, '0, 0, 1'b0);
    addRow(dteMisc, clrCROBAR, '0, 0, 1'b0);
    addRow(dteDiagFunc, funcClrReset, '0, 5, 1'b0);
    repeat (2) @(posedge clk);
    reqPending <= 1'b1;
    @(negedge clk);
    assert (crobar && !diagStrobe && !ebusDriving && ebusDriveData == '0 && !replyValid &&
            !reqCreditReturn)
      else noteMismatch("outputs not at their reset values");
    holding = 1'b0;
    for (int i = 0; i < NumRows; i++) begin
      @(posedge clk);
      while (sent - returns >= ReqDepth) begin   // out of request credits
        reqValid <= 1'b0;
        offerReplyCredit(holding);
        @(posedge clk);
      end
      holding = rows[i].hold;
      reqValid <= 1'b1;
      reqType  <= rows[i].kind;
      diagReq  <= rows[i].func;
      reqData  <= rows[i].data;
      reqTime  <= TickWidth'(tbTick + rows[i].offset);
      sentTime[i] = tbTick + rows[i].offset;
      sent++;
      owed++;
      offerReplyCredit(holding);
    end
    @(posedge clk);
    reqValid <= 1'b0;
    offerReplyCredit(1'b0);
    while (replies < NumRows) begin
      @(posedge clk);
      offerReplyCredit(1'b0);
    end
    repeat (4) @(posedge clk);
    assert (replies == NumRows && grants == NumRows && returns == sent)
      else noteMismatch($sformatf("%0d replies, %0d grants, %0d returns for %0d requests",
                                  replies, grants, returns, sent));
    assert (strobes == strobeRows)
      else noteMismatch($sformatf("%0d strobe cycles, expected %0d", strobes, strobeRows));
    assert (!crobar) else noteMismatch("crobar still set after clear");
    $display("%0d errors, %0d replies, %0d credit returns", errorCount, replies, returns);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
logic/dtePkg.sv
logic/dteIfc.sv
logic/creditFifo.sv
logic/dteDecode.sv
logic/dteExecute.sv
logic/dteResult.sv
logic/dteTop.sv
testbench/dteTb.sv

/* Bender.yml */
package:
  name: dte_frontend

sources:
  - logic/dtePkg.sv
  - logic/dteIfc.sv
  - logic/creditFifo.sv
  - logic/dteDecode.sv
  - logic/dteExecute.sv
  - logic/dteResult.sv
  - logic/dteTop.sv
  - target: test
    files:
      - testbench/dteTb.sv
